//--- include/fm_radio_cfg.svh
`ifndef FM_RADIO_CFG_SVH
`define FM_RADIO_CFG_SVH

// Sample width of the audio path
`define FM_DATA_SIZE 32

// Fraction bits of the fixed-point format
`define FM_QUANT_BITS 10

// Gain output shift of fourteen minus the fraction bits
`define FM_GAIN_SHIFT (14 - `FM_QUANT_BITS)

// Depth of every FIFO
`define FM_FIFO_DEPTH 16

// Deemphasis coefficients in Q10
`define FM_IIR_X0 (32'sd178)
`define FM_IIR_X1 (32'sd178)
`define FM_IIR_Y1 (-32'sd666)

// Unity volume in Q10
`define FM_VOLUME_RESET (32'sd1024)

`endif

//--- logic/fm_pkg.sv
`default_nettype none

`include "fm_radio_cfg.svh"

package fm_pkg;

    typedef logic signed [`FM_DATA_SIZE-1:0] sample_t;

    // Holds (lpr, lmr) before the matrix, (left, right) after it
    typedef struct packed {
        sample_t first;
        sample_t second;
    } stereo_pair_t;

    // Product kept in the low word, then shifted back to integer scale
    function automatic sample_t dequantise(input sample_t a, input sample_t b);
        sample_t prod;
        prod = a * b;
        return prod >>> `FM_QUANT_BITS;
    endfunction

endpackage

`default_nettype wire

//--- logic/sample_fifo.sv
`default_nettype none

module sample_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  wire logic             clock,
    input  wire logic             i_arst_n,

    input  wire logic             i_wr,
    input  wire logic [WIDTH-1:0] i_din,
    output logic                  o_full,

    input  wire logic             i_rd,
    output logic [WIDTH-1:0]      o_dout,
    output logic                  o_empty
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];

    // Extra top bit tells a full FIFO from an empty one
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        do_wr;
    logic        do_rd;

    assign do_wr = i_wr && !o_full;
    assign do_rd = i_rd && !o_empty;

    always_ff @(posedge clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (do_wr) begin
            mem[wr_ptr[AW-1:0]] <= i_din;
        end
    end

    assign o_empty = (wr_ptr == rd_ptr);
    assign o_full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                     (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // Show-ahead head entry
    assign o_dout = mem[rd_ptr[AW-1:0]];

endmodule

`default_nettype wire

//--- logic/stereo_matrix.sv
`default_nettype none

module stereo_matrix (
    input  wire logic                 clock,
    input  wire logic                 i_arst_n,

    input  wire fm_pkg::stereo_pair_t i_in_pair,
    input  wire logic                 i_in_empty,
    output logic                      o_in_rd,

    output fm_pkg::stereo_pair_t      o_out_pair,
    output logic                      o_out_wr,
    input  wire logic                 i_out_full
);

    logic valid_q;
    logic drain;

    // Register leaves this cycle
    assign drain = valid_q && !i_out_full;

    // Pop when the register is free or being emptied
    assign o_in_rd = !i_in_empty && (!valid_q || drain);

    always_ff @(posedge clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= 1'b0;
        end else if (o_in_rd) begin
            valid_q <= 1'b1;
        end else if (drain) begin
            valid_q <= 1'b0;
        end
    end

    // first is lpr, second is lmr on the way in
    always_ff @(posedge clock) begin
        if (o_in_rd) begin
            o_out_pair.first  <= i_in_pair.first + i_in_pair.second;
            o_out_pair.second <= i_in_pair.first - i_in_pair.second;
        end
    end

    assign o_out_wr = valid_q;

endmodule

`default_nettype wire

//--- logic/deemphasis_iir.sv
`default_nettype none

`include "fm_radio_cfg.svh"

module deemphasis_iir (
    input  wire logic                 clock,
    input  wire logic                 i_arst_n,

    input  wire fm_pkg::stereo_pair_t i_in_pair,
    input  wire logic                 i_in_wr,
    output logic                      o_in_full,

    output fm_pkg::stereo_pair_t      o_out_pair,
    output logic                      o_out_wr,
    input  wire logic                 i_out_full
);

    // One filter step for a single channel
    function automatic fm_pkg::sample_t iir_step(
        input fm_pkg::sample_t x,
        input fm_pkg::sample_t x1,
        input fm_pkg::sample_t y1
    );
        return fm_pkg::dequantise(`FM_IIR_X0, x) +
               fm_pkg::dequantise(`FM_IIR_X1, x1) +
               fm_pkg::dequantise(`FM_IIR_Y1, y1);
    endfunction

    logic            valid_q;
    logic            accept;
    logic            drain;

    // Previous input and output per channel
    fm_pkg::sample_t left_x1;
    fm_pkg::sample_t left_y1;
    fm_pkg::sample_t right_x1;
    fm_pkg::sample_t right_y1;

    fm_pkg::sample_t left_y;
    fm_pkg::sample_t right_y;

    assign drain     = valid_q && !i_out_full;
    assign o_in_full = valid_q && i_out_full;
    assign accept    = i_in_wr && !o_in_full;

    assign left_y  = iir_step(i_in_pair.first, left_x1, left_y1);
    assign right_y = iir_step(i_in_pair.second, right_x1, right_y1);

    always_ff @(posedge clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q  <= 1'b0;
            left_x1  <= '0;
            left_y1  <= '0;
            right_x1 <= '0;
            right_y1 <= '0;
        end else if (accept) begin
            valid_q  <= 1'b1;
            left_x1  <= i_in_pair.first;
            left_y1  <= left_y;
            right_x1 <= i_in_pair.second;
            right_y1 <= right_y;
        end else if (drain) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            o_out_pair.first  <= left_y;
            o_out_pair.second <= right_y;
        end
    end

    assign o_out_wr = valid_q;

endmodule

`default_nettype wire

//--- logic/volume_gain.sv
`default_nettype none

`include "fm_radio_cfg.svh"

module volume_gain (
    input  wire logic                 clock,
    input  wire logic                 i_arst_n,

    input  wire logic                 i_volume_wr,
    input  wire fm_pkg::sample_t      i_volume,

    input  wire fm_pkg::stereo_pair_t i_in_pair,
    input  wire logic                 i_in_wr,
    output logic                      o_in_full,

    output fm_pkg::sample_t           o_left,
    output fm_pkg::sample_t           o_right,
    output logic                      o_out_wr,
    input  wire logic                 i_left_full,
    input  wire logic                 i_right_full
);

    logic            valid_q;
    logic            out_blocked;
    logic            accept;
    fm_pkg::sample_t volume;
    fm_pkg::sample_t left_gain;
    fm_pkg::sample_t right_gain;

    // Both channels move together, so either full FIFO stalls the pair
    assign out_blocked = i_left_full || i_right_full;
    assign o_out_wr    = valid_q && !out_blocked;
    assign o_in_full   = valid_q && out_blocked;
    assign accept      = i_in_wr && !o_in_full;

    always_ff @(posedge clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            volume <= `FM_VOLUME_RESET;
        end else if (i_volume_wr) begin
            volume <= i_volume;
        end
    end

    always_ff @(posedge clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (o_out_wr) begin
            valid_q <= 1'b0;
        end
    end

    always_comb begin
        left_gain  = fm_pkg::dequantise(i_in_pair.first, volume) <<< `FM_GAIN_SHIFT;
        right_gain = fm_pkg::dequantise(i_in_pair.second, volume) <<< `FM_GAIN_SHIFT;
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            o_left  <= left_gain;
            o_right <= right_gain;
        end
    end

endmodule

`default_nettype wire

//--- logic/fm_stereo_top.sv
`default_nettype none

`include "fm_radio_cfg.svh"

module fm_stereo_top (
    input  wire logic                 clock,
    input  wire logic                 i_arst_n,

    input  wire logic                 i_mpx_wr,
    input  wire fm_pkg::stereo_pair_t i_mpx,
    output logic                      o_mpx_full,

    input  wire logic                 i_volume_wr,
    input  wire fm_pkg::sample_t      i_volume,

    input  wire logic                 i_left_rd,
    output fm_pkg::sample_t           o_left_data,
    output logic                      o_left_empty,

    input  wire logic                 i_right_rd,
    output fm_pkg::sample_t           o_right_data,
    output logic                      o_right_empty
);

    fm_pkg::stereo_pair_t mpx_pair;
    logic                 mpx_empty;
    logic                 mpx_rd;

    fm_pkg::stereo_pair_t mtx_pair;
    logic                 mtx_wr;
    logic                 mtx_full;

    fm_pkg::stereo_pair_t iir_pair;
    logic                 iir_wr;
    logic                 iir_full;

    fm_pkg::sample_t      gain_left;
    fm_pkg::sample_t      gain_right;
    logic                 gain_wr;
    logic                 left_full;
    logic                 right_full;

    // lpr/lmr pairs are always written together
    sample_fifo #(
        .WIDTH($bits(fm_pkg::stereo_pair_t)),
        .DEPTH(`FM_FIFO_DEPTH)
    ) u_mpx_fifo (
        .clock   (clock),
        .i_arst_n(i_arst_n),
        .i_wr    (i_mpx_wr),
        .i_din   (i_mpx),
        .o_full  (o_mpx_full),
        .i_rd    (mpx_rd),
        .o_dout  (mpx_pair),
        .o_empty (mpx_empty)
    );

    stereo_matrix u_stereo_matrix (
        .clock     (clock),
        .i_arst_n  (i_arst_n),
        .i_in_pair (mpx_pair),
        .i_in_empty(mpx_empty),
        .o_in_rd   (mpx_rd),
        .o_out_pair(mtx_pair),
        .o_out_wr  (mtx_wr),
        .i_out_full(mtx_full)
    );

    deemphasis_iir u_deemphasis_iir (
        .clock     (clock),
        .i_arst_n  (i_arst_n),
        .i_in_pair (mtx_pair),
        .i_in_wr   (mtx_wr),
        .o_in_full (mtx_full),
        .o_out_pair(iir_pair),
        .o_out_wr  (iir_wr),
        .i_out_full(iir_full)
    );

    volume_gain u_volume_gain (
        .clock       (clock),
        .i_arst_n    (i_arst_n),
        .i_volume_wr (i_volume_wr),
        .i_volume    (i_volume),
        .i_in_pair   (iir_pair),
        .i_in_wr     (iir_wr),
        .o_in_full   (iir_full),
        .o_left      (gain_left),
        .o_right     (gain_right),
        .o_out_wr    (gain_wr),
        .i_left_full (left_full),
        .i_right_full(right_full)
    );

    // Output FIFOs are read independently
    sample_fifo #(
        .WIDTH(`FM_DATA_SIZE),
        .DEPTH(`FM_FIFO_DEPTH)
    ) u_left_fifo (
        .clock   (clock),
        .i_arst_n(i_arst_n),
        .i_wr    (gain_wr),
        .i_din   (gain_left),
        .o_full  (left_full),
        .i_rd    (i_left_rd),
        .o_dout  (o_left_data),
        .o_empty (o_left_empty)
    );

    sample_fifo #(
        .WIDTH(`FM_DATA_SIZE),
        .DEPTH(`FM_FIFO_DEPTH)
    ) u_right_fifo (
        .clock   (clock),
        .i_arst_n(i_arst_n),
        .i_wr    (gain_wr),
        .i_din   (gain_right),
        .o_full  (right_full),
        .i_rd    (i_right_rd),
        .o_dout  (o_right_data),
        .o_empty (o_right_empty)
    );

endmodule

`default_nettype wire

//--- verification/tb_fm_stereo.sv
`default_nettype none

`include "fm_radio_cfg.svh"

module tb_fm_stereo;

    timeunit 1ns;
    timeprecision 100ps;

    logic                 clock = 1'b0;
    logic                 i_arst_n;
    logic                 i_mpx_wr;
    fm_pkg::stereo_pair_t i_mpx;
    logic                 o_mpx_full;
    logic                 i_volume_wr;
    fm_pkg::sample_t      i_volume;
    logic                 i_left_rd;
    fm_pkg::sample_t      o_left_data;
    logic                 o_left_empty;
    logic                 i_right_rd;
    fm_pkg::sample_t      o_right_data;
    logic                 o_right_empty;

    // Expected outputs in the order the writes were accepted
    fm_pkg::sample_t exp_left[$];
    fm_pkg::sample_t exp_right[$];

    // Model state
    fm_pkg::sample_t m_left_x1;
    fm_pkg::sample_t m_left_y1;
    fm_pkg::sample_t m_right_x1;
    fm_pkg::sample_t m_right_y1;
    fm_pkg::sample_t m_volume;

    logic [31:0] lfsr_state;
    int          errors;
    int          checks;
    int          tests_run;
    int          left_reads;
    logic        aborted;

    fm_stereo_top uut (
        .clock        (clock),
        .i_arst_n     (i_arst_n),
        .i_mpx_wr     (i_mpx_wr),
        .i_mpx        (i_mpx),
        .o_mpx_full   (o_mpx_full),
        .i_volume_wr  (i_volume_wr),
        .i_volume     (i_volume),
        .i_left_rd    (i_left_rd),
        .o_left_data  (o_left_data),
        .o_left_empty (o_left_empty),
        .i_right_rd   (i_right_rd),
        .o_right_data (o_right_data),
        .o_right_empty(o_right_empty)
    );

    always #2 clock = ~clock;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // Full product, keep the low word, then drop the fraction bits
    function automatic fm_pkg::sample_t fixmul(input fm_pkg::sample_t a,
                                                input fm_pkg::sample_t b);
        logic signed [63:0] full;
        fm_pkg::sample_t    low;
        full = 64'(a) * 64'(b);
        low = full[31:0];
        return low >>> `FM_QUANT_BITS;
    endfunction

    function automatic fm_pkg::stereo_pair_t make_pair(input fm_pkg::sample_t lpr,
                                                        input fm_pkg::sample_t lmr);
        fm_pkg::stereo_pair_t p;
        p.first = lpr;
        p.second = lmr;
        return p;
    endfunction

    task automatic model_push(input fm_pkg::stereo_pair_t in_pair);
        fm_pkg::sample_t left;
        fm_pkg::sample_t right;
        fm_pkg::sample_t left_y;
        fm_pkg::sample_t right_y;
        left = in_pair.first + in_pair.second;
        right = in_pair.first - in_pair.second;
        left_y = fixmul(left, `FM_IIR_X0) + fixmul(m_left_x1, `FM_IIR_X1) +
                 fixmul(m_left_y1, `FM_IIR_Y1);
        right_y = fixmul(right, `FM_IIR_X0) + fixmul(m_right_x1, `FM_IIR_X1) +
                  fixmul(m_right_y1, `FM_IIR_Y1);
        m_left_x1 = left;
        m_left_y1 = left_y;
        m_right_x1 = right;
        m_right_y1 = right_y;
        exp_left.push_back(fixmul(left_y, m_volume) <<< `FM_GAIN_SHIFT);
        exp_right.push_back(fixmul(right_y, m_volume) <<< `FM_GAIN_SHIFT);
    endtask

    task automatic compare_sample(input fm_pkg::sample_t got, input fm_pkg::sample_t exp,
                                  input string what);
        checks++;
        if (got !== exp) begin
            $display("** Error at %0t: %s sample is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic compare_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    // One clock of stimulus with reads checked before the write updates the model
    task automatic cycle(input logic want_wr, input fm_pkg::stereo_pair_t pair,
                         input logic want_l, input logic want_r, output logic wrote);
        i_left_rd = want_l && !o_left_empty;
        i_right_rd = want_r && !o_right_empty;
        if (i_left_rd) begin
            left_reads++;
            if (exp_left.size() == 0) begin
                $display("Left FIFO gave a sample nobody wrote, at %0t", $time);
                errors++;
            end else begin
                compare_sample(o_left_data, exp_left.pop_front(), "left");
            end
        end
        if (i_right_rd) begin
            if (exp_right.size() == 0) begin
                $display("Right FIFO gave a sample nobody wrote, at %0t", $time);
                errors++;
            end else begin
                compare_sample(o_right_data, exp_right.pop_front(), "right");
            end
        end
        // A write is offered even while full and only taken when full is low
        wrote = want_wr && !o_mpx_full;
        i_mpx_wr = want_wr;
        i_mpx = pair;
        if (wrote) begin
            model_push(pair);
        end
        @(posedge clock);
        #1;
    endtask

    task automatic idle(input int n, input logic read);
        logic wrote;
        for (int i = 0; i < n; i++) begin
            cycle(1'b0, '0, read, read, wrote);
        end
    endtask

    task automatic set_volume(input fm_pkg::sample_t v);
        i_volume_wr = 1'b1;
        i_volume = v;
        m_volume = v;
        @(posedge clock);
        #1;
        i_volume_wr = 1'b0;
    endtask

    task automatic reset_dut();
        i_arst_n = 1'b0;
        i_mpx_wr = 1'b0;
        i_left_rd = 1'b0;
        i_right_rd = 1'b0;
        i_volume_wr = 1'b0;
        repeat (16) @(posedge clock);
        #1;
        i_arst_n = 1'b1;
        m_left_x1 = '0;
        m_left_y1 = '0;
        m_right_x1 = '0;
        m_right_y1 = '0;
        m_volume = `FM_VOLUME_RESET;
        exp_left.delete();
        exp_right.delete();
    endtask

    task automatic drain_outputs(input int limit, input string tag);
        int   n;
        logic wrote;
        n = 0;
        while ((exp_left.size() != 0 || exp_right.size() != 0) && n < limit) begin
            cycle(1'b0, '0, 1'b1, 1'b1, wrote);
            n++;
        end
        if (exp_left.size() != 0 || exp_right.size() != 0) begin
            $display("Timed out in %s: %0d left and %0d right samples never arrived",
                     tag, exp_left.size(), exp_right.size());
            errors++;
            aborted = 1'b1;
        end
        idle(4, 1'b1);
        compare_flag(o_left_empty, 1'b1, "o_left_empty after drain");
        compare_flag(o_right_empty, 1'b1, "o_right_empty after drain");
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic test_reset_state();
        int e0;
        e0 = errors;
        compare_flag(o_mpx_full, 1'b0, "o_mpx_full");
        for (int i = 0; i < 20; i++) begin
            compare_flag(o_left_empty, 1'b1, "o_left_empty");
            compare_flag(o_right_empty, 1'b1, "o_right_empty");
            idle(1, 1'b1);
        end
        report_test("reset_state", e0);
    endtask

    task automatic test_unity_volume();
        fm_pkg::stereo_pair_t seq[8];
        logic                 wrote;
        int                   e0;
        e0 = errors;
        seq[0] = make_pair(4096, 0);
        seq[1] = make_pair(0, 0);
        seq[2] = make_pair(0, 0);
        seq[3] = make_pair(0, 4096);
        seq[4] = make_pair(-3000, 500);
        seq[5] = make_pair(2000, -2500);
        seq[6] = make_pair(-32768, 32767);
        seq[7] = make_pair(123456, -654321);
        foreach (seq[i]) begin
            cycle(1'b1, seq[i], 1'b0, 1'b0, wrote);
            compare_flag(wrote, 1'b1, "write accepted");
        end
        drain_outputs(100, "unity_volume");
        report_test("unity_volume", e0);
    endtask

    task automatic test_volume_change();
        logic wrote;
        int   e0;
        e0 = errors;
        set_volume(2560);
        for (int i = 0; i < 6; i++) begin
            cycle(1'b1, make_pair(700 * i - 1500, 300 - 250 * i), 1'b0, 1'b0, wrote);
        end
        drain_outputs(100, "volume_change");
        set_volume(-512);
        for (int i = 0; i < 4; i++) begin
            cycle(1'b1, make_pair(9000 - 4000 * i, 1200 * i), 1'b0, 1'b0, wrote);
        end
        drain_outputs(100, "volume_change");
        report_test("volume_change", e0);
    endtask

    task automatic test_back_pressure();
        logic wrote;
        int   n;
        int   accepted;
        int   reads_before;
        int   e0;
        e0 = errors;
        n = 0;
        accepted = 0;
        reads_before = left_reads;
        while (!o_mpx_full && n < 100) begin
            cycle(1'b1, make_pair(37 * n - 500, 250 - 11 * n), 1'b0, 1'b0, wrote);
            if (wrote) begin
                accepted++;
            end
            n++;
        end
        if (!o_mpx_full) begin
            $display("Timed out in back_pressure: o_mpx_full never rose");
            errors++;
            aborted = 1'b1;
        end
        // Held writes while full must not be taken
        for (int i = 0; i < 3; i++) begin
            cycle(1'b1, make_pair(-1, -1), 1'b0, 1'b0, wrote);
            compare_flag(wrote, 1'b0, "write while full");
        end
        drain_outputs(200, "back_pressure");
        compare_count(left_reads - reads_before, accepted, "outputs after back-pressure");
        compare_flag(o_mpx_full, 1'b0, "o_mpx_full after drain");
        report_test("back_pressure", e0);
    endtask

    task automatic test_random_stream();
        logic [31:0] a;
        logic [31:0] b;
        logic        want_wr;
        logic        want_l;
        logic        want_r;
        logic        wrote;
        int          written;
        int          n;
        int          e0;
        e0 = errors;
        reset_dut();
        written = 0;
        n = 0;
        while ((written < 200 || exp_left.size() != 0 || exp_right.size() != 0) && n < 4000) begin
            a = take_bits(16);
            b = take_bits(16);
            want_wr = (written < 200) && (take_bits(2) != 0);
            want_l = (take_bits(1) != 0);
            want_r = (take_bits(1) != 0);
            cycle(want_wr, make_pair({{16{a[15]}}, a[15:0]}, {{16{b[15]}}, b[15:0]}),
                  want_l, want_r, wrote);
            if (wrote) begin
                written++;
            end
            n++;
        end
        if (written < 200 || exp_left.size() != 0 || exp_right.size() != 0) begin
            $display("Timed out in random_stream after %0d writes", written);
            errors++;
            aborted = 1'b1;
        end
        idle(4, 1'b1);
        compare_flag(o_left_empty, 1'b1, "o_left_empty after stream");
        compare_flag(o_right_empty, 1'b1, "o_right_empty after stream");
        report_test("random_stream", e0);
    endtask

    initial begin
        i_arst_n = 1'b0;
        i_mpx_wr = 1'b0;
        i_mpx = '0;
        i_volume_wr = 1'b0;
        i_volume = '0;
        i_left_rd = 1'b0;
        i_right_rd = 1'b0;
        lfsr_state = 32'h70f1;
        errors = 0;
        checks = 0;
        tests_run = 0;
        left_reads = 0;
        aborted = 1'b0;
        reset_dut();
        test_reset_state();
        if (!aborted) test_unity_volume();
        if (!aborted) test_volume_change();
        if (!aborted) test_back_pressure();
        if (!aborted) test_random_stream();
        $display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
logic/fm_pkg.sv
logic/sample_fifo.sv
logic/stereo_matrix.sv
logic/deemphasis_iir.sv
logic/volume_gain.sv
logic/fm_stereo_top.sv
verification/tb_fm_stereo.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the stereo back end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -f sources.f --top-module tb_fm_stereo \
    -Mdir "$OBJ" -o tb_fm_stereo
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/tb_fm_stereo" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi
